// ==== filelist.f ====
+incdir+common
common/sdCmdPkg.sv
common/axiLitePkg.sv
hw/spiLink/spiTxFifo.sv
hw/spiLink/spiByteShifter.sv
hw/sdCmd/sdCmdSender.sv
hw/sdCmdRegs.sv
hw/sdCmdTop.sv
dv/sdCmd_assertions.sv
dv/sdCardModel.sv
dv/sdCmdTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module sdCmdTb -f filelist.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== dv/sdCmdTb.sv ====
`timescale 1ns/100ps
`include "sdSpi_defs.svh"

module sdCmdTb;

  import sdCmdPkg::*;
  import axiLitePkg::*;

  localparam int NumEntries = 9;
  localparam int ByteCycles = 16 * `SPI_CLK_DIV + 2;
  // One extra entry covers the busy start check
  localparam int CycleLimit = (NumEntries + 1) * (7 + `SD_RESP_TIMEOUT + 6) * ByteCycles + 1000;

  typedef struct packed {
    sdOpcode_e   cmd;
    logic [31:0] arg;
    logic [7:0]  crc;
    logic [7:0]  delay;
    logic [7:0]  r1;
    logic [31:0] r7;
    logic        expTimeout;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst;
  axiLiteReq_t axiReq;
  axiLiteRsp_t axiRsp;
  logic        sclk;
  logic        mosi;
  logic        csN;
  logic        miso;
  logic [7:0]  respDelay;
  logic [7:0]  respR1;
  logic [31:0] respR7;
  logic [47:0] frameSeen;
  int          cmdCount;

  entry_t      stimTab [NumEntries];
  int          seed = 32'hb4bb_5025;
  int          errCount = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          cycleCnt = 0;
  // R7 only changes when a CMD8 runs
  logic [31:0] expR7 = 32'h0;

  always #5 clk = ~clk;

  sdCmdTop sdCmdTop_i (
    .clk, .rst, .axiReq, .axiRsp, .sclk, .mosi, .csN, .miso
  );

  sdCardModel card_i (
    .sclk, .mosi, .csN, .miso, .respDelay, .respR1, .respR7, .frameSeen, .cmdCount
  );

  bind sdCmdTop sdCmdAssertions assertions_i (
    .clk(clk), .rst(rst), .txWen(txWen), .txFull(txFull), .rxRdyClr(rxRdyClr),
    .bvalid(axiRsp.bvalid), .bready(axiReq.bready), .rvalid(axiRsp.rvalid),
    .rready(axiReq.rready), .cmdStart(cmdStart), .ready(result.ready)
  );

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt == CycleLimit) begin
      $display("Run stopped, %0d cycles passed without finishing the tests", CycleLimit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkResult(input string name, input sdCmdResult_t got,
                             input sdCmdResult_t exp);
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %s got rdy %h to %h r1 0x%h r7 0x%h expected rdy %h to %h r1 0x%h r7 0x%h",
               name, got.ready, got.timeout, got.r1, got.r7,
               exp.ready, exp.timeout, exp.r1, exp.r7);
    end
  endtask

  task automatic checkResp(input string name, input axiResp_e got, input axiResp_e exp);
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////
  // AXI4-Lite master
  ////////////////////

  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output axiResp_e resp);
    @(negedge clk);
    axiReq.awvalid = 1'b1;
    axiReq.awaddr  = addr;
    axiReq.wvalid  = 1'b1;
    axiReq.wdata   = data;
    axiReq.wstrb   = strb;
    axiReq.bready  = 1'b0;
    // bvalid up means the write was taken
    do @(negedge clk); while (!axiRsp.bvalid);
    resp           = axiRsp.bresp;
    axiReq.awvalid = 1'b0;
    axiReq.wvalid  = 1'b0;
    // Response sits one cycle with bready low before it is taken
    @(negedge clk);
    axiReq.bready = 1'b1;
    @(negedge clk);
    axiReq.bready = 1'b0;
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                         output axiResp_e resp);
    @(negedge clk);
    axiReq.arvalid = 1'b1;
    axiReq.araddr  = addr;
    axiReq.rready  = 1'b0;
    do @(negedge clk); while (!axiRsp.rvalid);
    axiReq.arvalid = 1'b0;
    // Data is taken after one cycle with rready low
    @(negedge clk);
    data          = axiRsp.rdata;
    resp          = axiRsp.rresp;
    axiReq.rready = 1'b1;
    @(negedge clk);
    axiReq.rready = 1'b0;
  endtask

  task automatic readResult(output sdCmdResult_t res);
    logic [31:0] st;
    logic [31:0] r7w;
    axiResp_e    resp;
    axiRead(`REG_STATUS, st, resp);
    checkResp("STATUS rresp", resp, OKAY);
    axiRead(`REG_R7, r7w, resp);
    checkResp("R7 rresp", resp, OKAY);
    res = '{ready: st[0], timeout: st[1], r1: st[15:8], r7: r7w};
  endtask

  // Start bit 8 set with chip select bit 9 low
  task automatic startCmd(input logic [7:0] cmd);
    axiResp_e resp;
    axiWrite(`REG_CMD, {22'd0, 1'b0, 1'b1, cmd}, 4'b0011, resp);
    checkResp("CMD bresp", resp, OKAY);
    // Ready falls one cycle after the start pulse
    repeat (2) @(negedge clk);
  endtask

  task automatic waitReady();
    logic [31:0] st;
    axiResp_e    resp;
    do begin
      axiRead(`REG_STATUS, st, resp);
    end while (!st[0]);
  endtask

  task automatic setEntry(input int idx, input sdOpcode_e cmd, input logic [7:0] crc,
                          input logic [7:0] delay, input logic [7:0] r1,
                          input logic [31:0] r7, input logic expTo);
    stimTab[idx] = '{cmd: cmd, arg: $random(seed), crc: crc, delay: delay,
                     r1: r1, r7: r7, expTimeout: expTo};
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testsRun++;
    if (errCount > errBefore) begin
      testsFailed++;
      $display("test %s: %0d mismatches", name, errCount - errBefore);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  ////////////////////
  // Table entry run
  ////////////////////

  task automatic runEntry(input int idx);
    entry_t       e;
    logic [31:0]  rd;
    axiResp_e     resp;
    int           countBefore;
    int           errBefore;
    logic         silent;
    sdCmdResult_t got;
    sdCmdResult_t exp;
    e           = stimTab[idx];
    errBefore   = errCount;
    respDelay   = e.delay;
    respR1      = e.r1;
    respR7      = e.r7;
    countBefore = cmdCount;
    axiWrite(`REG_ARG, e.arg, 4'hF, resp);
    checkResp("ARG bresp", resp, OKAY);
    axiWrite(`REG_CRC, {24'd0, e.crc}, 4'h1, resp);
    checkResp("CRC bresp", resp, OKAY);
    axiRead(`REG_ARG, rd, resp);
    checkWord("ARG readback", rd, e.arg);
    axiRead(`REG_CRC, rd, resp);
    checkWord("CRC readback", rd, {24'd0, e.crc});
    startCmd(e.cmd);
    waitReady();
    readResult(got);
    // Expected outcome from the card setup
    silent = int'(e.delay) > `SD_RESP_TIMEOUT;
    if (e.cmd == CMD8) begin
      expR7 = (!silent && e.r1 != 8'h05) ? e.r7 : 32'h0;
    end
    exp = '{ready: 1'b1, timeout: e.expTimeout, r1: silent ? 8'hFF : e.r1, r7: expR7};
    checkResult("result", got, exp);
    checkWord("commands at card", 32'(cmdCount - countBefore), 32'd1);
    checkByte("card cmd", frameSeen[47:40], e.cmd);
    checkWord("card arg", frameSeen[39:8], e.arg);
    checkByte("card crc", frameSeen[7:0], e.crc);
    reportTest($sformatf("entry %0d cmd 0x%h delay %0d", idx, e.cmd, e.delay), errBefore);
  endtask

  initial begin
    logic [31:0]  rd;
    axiResp_e     resp;
    sdCmdResult_t got;
    int           errBefore;
    int           countBefore;
    rst       = 1'b1;
    axiReq    = '0;
    respDelay = 8'd0;
    respR1    = 8'h00;
    respR7    = 32'h0;

    setEntry(0, CMD0, 8'h95, 8'd0, 8'h01, 32'h0, 1'b0);
    setEntry(1, CMD17, 8'h55, 8'd10, 8'h00, 32'h0, 1'b0);
    setEntry(2, CMD17, 8'h3B, 8'd0, 8'h00, 32'h0, 1'b0);
    setEntry(3, CMD0, 8'h95, 8'd10, 8'h01, 32'h0, 1'b0);
    setEntry(4, CMD8, 8'h87, 8'd3, 8'h01, 32'h0000_01AA, 1'b0);
    setEntry(5, CMD17, 8'hE1, 8'd100, 8'h00, 32'h0, 1'b1);
    setEntry(6, CMD55, 8'h65, 8'd100, 8'h01, 32'h0, 1'b0);
    setEntry(7, CMD8, 8'h87, 8'd0, 8'h05, 32'hDEAD_BEEF, 1'b0);
    setEntry(8, CMD8, 8'h87, 8'd100, 8'h01, 32'h0000_01AA, 1'b0);

    repeat (4) @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);

    // Reset values
    errBefore = errCount;
    readResult(got);
    checkResult("reset result", got, '{ready: 1'b1, timeout: 1'b0, r1: 8'h00, r7: 32'h0});
    checkByte("csN", {7'd0, csN}, 8'h01);
    reportTest("reset state", errBefore);

    for (int i = 0; i < NumEntries; i++) begin
      runEntry(i);
    end

    // Second start while busy must be dropped
    errBefore   = errCount;
    countBefore = cmdCount;
    respDelay   = 8'd10;
    respR1      = 8'h01;
    startCmd(CMD0);
    axiWrite(`REG_CMD, {22'd0, 1'b0, 1'b1, CMD17}, 4'b0011, resp);
    checkResp("busy CMD bresp", resp, OKAY);
    waitReady();
    repeat (20 * ByteCycles) @(negedge clk);
    checkWord("commands at card", 32'(cmdCount - countBefore), 32'd1);
    checkByte("card cmd", frameSeen[47:40], CMD0);
    axiRead(`REG_CMD, rd, resp);
    checkByte("CMD readback", rd[7:0], CMD0);
    reportTest("start while busy", errBefore);

    errBefore = errCount;
    axiRead(8'h20, rd, resp);
    checkResp("unmapped rresp", resp, SLVERR);
    checkWord("unmapped rdata", rd, 32'h0);
    reportTest("unmapped offset", errBefore);

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== dv/sdCardModel.sv ====
`timescale 1ns/100ps
`include "sdSpi_defs.svh"

module sdCardModel (
  input  logic        sclk,
  input  logic        mosi,
  input  logic        csN,
  output logic        miso,
  input  logic [7:0]  respDelay,
  input  logic [7:0]  respR1,
  input  logic [31:0] respR7,
  output logic [47:0] frameSeen,
  output int          cmdCount
);

  logic [7:0]  rxShift = 8'hFF;
  logic [7:0]  txShift = 8'hFF;
  logic [7:0]  nextOut = 8'hFF;
  logic [7:0]  cmdByte = 8'h00;
  logic [7:0]  latDelay = 8'd0;
  logic [7:0]  latR1 = 8'h00;
  logic [31:0] latR7 = 32'h0;
  int          bitCnt = 0;
  int          capIdx = 0;
  int          respIdx = 0;
  logic        prevFF = 1'b0;
  logic        capturing = 1'b0;
  logic        responding = 1'b0;

  initial begin
    frameSeen = '0;
    cmdCount  = 0;
  end

  assign miso = txShift[7];

  // Byte the card returns at position idx after the command
  function automatic logic [7:0] respByte(input int idx);
    int d;
    d = int'(latDelay);
    if (d > `SD_RESP_TIMEOUT || idx < d) begin
      return 8'hFF;
    end
    if (idx == d) begin
      return latR1;
    end
    // R7 follows R1 for CMD8 unless it was rejected
    if (cmdByte == 8'h48 && latR1 != 8'h05 && idx <= d + 4) begin
      return latR7[8*(d+4-idx) +: 8];
    end
    return 8'hFF;
  endfunction

  task takeByte(input logic [7:0] b);
    if (capturing) begin
      frameSeen = {frameSeen[39:0], b};
      capIdx    = capIdx + 1;
      if (capIdx == 6) begin
        capturing  = 1'b0;
        responding = 1'b1;
        cmdCount   = cmdCount + 1;
        latDelay   = respDelay;
        latR1      = respR1;
        latR7      = respR7;
        respIdx    = 0;
        nextOut    = respByte(0);
      end else begin
        nextOut = 8'hFF;
      end
    end else if (prevFF && b[7:6] == 2'b01) begin
      // Command start after a 0xFF byte
      capturing  = 1'b1;
      responding = 1'b0;
      capIdx     = 1;
      cmdByte    = b;
      frameSeen  = {40'd0, b};
      nextOut    = 8'hFF;
    end else if (responding) begin
      respIdx = respIdx + 1;
      nextOut = respByte(respIdx);
    end else begin
      nextOut = 8'hFF;
    end
    prevFF = (b == 8'hFF);
  endtask

  // Mode 0, sample on the rising edge
  always @(posedge sclk) begin
    if (!csN) begin
      rxShift = {rxShift[6:0], mosi};
      bitCnt  = bitCnt + 1;
      if (bitCnt == 8) begin
        bitCnt = 0;
        takeByte(rxShift);
      end
    end
  end

  // Next byte loads on the last falling edge of a byte
  always @(negedge sclk) begin
    if (bitCnt == 0) begin
      txShift <= nextOut;
    end else begin
      txShift <= {txShift[6:0], 1'b1};
    end
  end

endmodule

// ==== dv/sdCmd_assertions.sv ====
`timescale 1ns/100ps

module sdCmdAssertions (
  input logic clk,
  input logic rst,
  input logic txWen,
  input logic txFull,
  input logic rxRdyClr,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic cmdStart,
  input logic ready
);

  // FIFO is never written while full
  noWriteWhenFull: assert property (@(posedge clk) disable iff (rst) !(txWen && txFull))
    else $error("txWen high while txFull");

  // Clear of rxRdy is a single cycle pulse
  clrOneCycle: assert property (@(posedge clk) disable iff (rst) rxRdyClr |=> !rxRdyClr)
    else $error("rxRdyClr longer than one cycle");

  ////////////////////
  // Bus responses hold until taken
  ////////////////////

  bHold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rHold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  startWhenReady: assert property (@(posedge clk) disable iff (rst) cmdStart |-> ready)
    else $error("cmdStart while sender busy");

endmodule

// ==== hw/sdCmdTop.sv ====
`timescale 1ns/100ps

module sdCmdTop (
  input  logic                    clk,
  input  logic                    rst,
  input  axiLitePkg::axiLiteReq_t axiReq,
  output axiLitePkg::axiLiteRsp_t axiRsp,
  output logic                    sclk,
  output logic                    mosi,
  output logic                    csN,
  input  logic                    miso
);

  import sdCmdPkg::*;

  sdCmdFrame_t  frame;
  sdCmdResult_t result;
  logic         cmdStart;
  // Sender side of the FIFO
  logic [7:0]   senderByte;
  logic         txWen;
  logic         txFull;
  // Shifter side of the FIFO
  logic [7:0]   fifoByte;
  logic         txPop;
  logic         txEmpty;
  logic [7:0]   rxByte;
  logic         rxRdy;
  logic         rxRdyClr;

  sdCmdRegs regs_i (
    .clk, .rst, .axiReq, .axiRsp, .frame, .cmdStart, .csN, .result
  );

  sdCmdSender sender_i (
    .clk, .rst, .frame, .cmdStart, .result,
    .txByte(senderByte), .txWen, .txFull, .txEmpty,
    .rxByte, .rxRdy, .rxRdyClr
  );

  spiTxFifo fifo_i (
    .clk, .rst, .wrByte(senderByte), .wrEn(txWen), .full(txFull),
    .rdByte(fifoByte), .rdEn(txPop), .empty(txEmpty)
  );

  spiByteShifter shifter_i (
    .clk, .rst, .txByte(fifoByte), .txEmpty, .txPop,
    .rxByte, .rxRdy, .rxRdyClr, .sclk, .mosi, .miso
  );

endmodule

// ==== hw/sdCmdRegs.sv ====
`timescale 1ns/100ps
`include "sdSpi_defs.svh"

module sdCmdRegs (
  input  logic                   clk,
  input  logic                   rst,
  input  axiLitePkg::axiLiteReq_t axiReq,
  output axiLitePkg::axiLiteRsp_t axiRsp,
  output sdCmdPkg::sdCmdFrame_t  frame,
  output logic                   cmdStart,
  output logic                   csN,
  input  sdCmdPkg::sdCmdResult_t result
);

  import axiLitePkg::*;

  logic        wrTake;
  logic        rdTake;
  logic        wrMapped;
  logic        rdMapped;
  logic [31:0] rdWord;
  logic        bValid;
  logic        rValid;
  axiResp_e    bResp;
  axiResp_e    rResp;
  logic [31:0] rData;

  // One outstanding write and one outstanding read
  assign wrTake = axiReq.awvalid && axiReq.wvalid && !bValid;
  assign rdTake = axiReq.arvalid && !rValid;

  assign axiRsp = '{awready: wrTake, wready: wrTake, bvalid: bValid, bresp: bResp,
                    arready: rdTake, rvalid: rValid, rdata: rData, rresp: rResp};

  always_comb begin
    case (axiReq.awaddr)
      `REG_CMD, `REG_ARG, `REG_CRC, `REG_STATUS, `REG_R7: wrMapped = 1'b1;
      default: wrMapped = 1'b0;
    endcase
  end

  // Read mux, STATUS packs ready, timeout and R1
  always_comb begin
    rdMapped = 1'b1;
    case (axiReq.araddr)
      `REG_CMD:    rdWord = {22'd0, csN, 1'b0, frame.cmd};
      `REG_ARG:    rdWord = frame.arg;
      `REG_CRC:    rdWord = {24'd0, frame.crc};
      `REG_STATUS: rdWord = {16'd0, result.r1, 6'd0, result.timeout, result.ready};
      `REG_R7:     rdWord = result.r7;
      default: begin
        rdWord   = '0;
        rdMapped = 1'b0;
      end
    endcase
  end

  ////////////////////
  // Handshake and control
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      bValid   <= 1'b0;
      rValid   <= 1'b0;
      cmdStart <= 1'b0;
      csN      <= 1'b1;
    end else begin
      cmdStart <= 1'b0;
      if (wrTake) begin
        bValid <= 1'b1;
      end else if (axiReq.bready) begin
        bValid <= 1'b0;
      end
      if (rdTake) begin
        rValid <= 1'b1;
      end else if (axiReq.rready) begin
        rValid <= 1'b0;
      end
      // Start bit 8 and chip select bit 9 sit in byte lane 1
      if (wrTake && axiReq.awaddr == `REG_CMD && axiReq.wstrb[1]) begin
        csN      <= axiReq.wdata[9];
        cmdStart <= axiReq.wdata[8] && result.ready;
      end
    end
  end

  ////////////////////
  // Frame and response data
  ////////////////////

  always_ff @(posedge clk) begin
    if (wrTake) begin
      bResp <= wrMapped ? OKAY : SLVERR;
    end
    if (rdTake) begin
      rData <= rdWord;
      rResp <= rdMapped ? OKAY : SLVERR;
    end
    // Frame is frozen while a command runs
    if (wrTake && result.ready) begin
      case (axiReq.awaddr)
        `REG_CMD: begin
          if (axiReq.wstrb[0]) begin
            frame.cmd <= axiReq.wdata[7:0];
          end
        end
        `REG_ARG: begin
          for (int i = 0; i < 4; i++) begin
            if (axiReq.wstrb[i]) begin
              frame.arg[8*i +: 8] <= axiReq.wdata[8*i +: 8];
            end
          end
        end
        `REG_CRC: begin
          if (axiReq.wstrb[0]) begin
            frame.crc <= axiReq.wdata[7:0];
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== hw/sdCmd/sdCmdSender.sv ====
`timescale 1ns/100ps
`include "sdSpi_defs.svh"

module sdCmdSender (
  input  logic                   clk,
  input  logic                   rst,
  input  sdCmdPkg::sdCmdFrame_t  frame,
  input  logic                   cmdStart,
  output sdCmdPkg::sdCmdResult_t result,
  output logic [7:0]             txByte,
  output logic                   txWen,
  input  logic                   txFull,
  input  logic                   txEmpty,
  input  logic [7:0]             rxByte,
  input  logic                   rxRdy,
  output logic                   rxRdyClr
);

  import sdCmdPkg::*;

  localparam logic [9:0] TimeoutLimit = 10'(`SD_RESP_TIMEOUT);

  sdSendState_e state;
  // 0 is the 0xFF preamble, 1 to 6 the frame bytes
  logic [2:0]   byteIdx;
  // Bytes taken after R1, CMD8 only
  logic [2:0]   respCtr;
  logic [9:0]   timeoutCnt;
  logic [7:0]   frameByte;
  logic         isCmd8;

  assign isCmd8 = (frame.cmd == CMD8);

  // Argument goes out most significant byte first
  always_comb begin
    case (byteIdx)
      3'd0:    frameByte = 8'hFF;
      3'd1:    frameByte = frame.cmd;
      3'd2:    frameByte = frame.arg[31:24];
      3'd3:    frameByte = frame.arg[23:16];
      3'd4:    frameByte = frame.arg[15:8];
      3'd5:    frameByte = frame.arg[7:0];
      default: frameByte = frame.crc;
    endcase
  end

  ////////////////////
  // Command FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      byteIdx    <= '0;
      respCtr    <= '0;
      timeoutCnt <= '0;
      txWen      <= 1'b0;
      rxRdyClr   <= 1'b0;
      result     <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          result.ready <= 1'b1;
          if (cmdStart) begin
            result.ready   <= 1'b0;
            result.timeout <= 1'b0;
            // Old R7 stays visible unless a new CMD8 runs
            if (isCmd8) begin
              result.r7 <= '0;
            end
            byteIdx <= '0;
            respCtr <= '0;
            state   <= ST_BYTE;
          end
        end
        // Stall here while the FIFO is full
        ST_BYTE: begin
          if (!txFull) begin
            txByte <= frameByte;
            txWen  <= 1'b1;
            state  <= ST_BYTE_GAP;
          end
        end
        // One idle cycle between FIFO writes
        ST_BYTE_GAP: begin
          txWen <= 1'b0;
          if (byteIdx == 3'd6) begin
            timeoutCnt <= '0;
            state      <= ST_DRAIN;
          end else begin
            byteIdx <= byteIdx + 3'd1;
            state   <= ST_BYTE;
          end
        end
        ST_DRAIN: begin
          if (txEmpty) begin
            state <= ST_POLL;
          end
        end
        // Poll byte and stale rxRdy clear leave together
        ST_POLL: begin
          if (!txFull) begin
            txByte     <= 8'hFF;
            txWen      <= 1'b1;
            rxRdyClr   <= 1'b1;
            timeoutCnt <= timeoutCnt + 10'd1;
            state      <= ST_POLL_DEL;
          end
        end
        // Lets the clear land before rxRdy is looked at
        ST_POLL_DEL: begin
          txWen    <= 1'b0;
          rxRdyClr <= 1'b0;
          state    <= ST_WAIT;
        end
        ST_WAIT: begin
          if (rxRdy) begin
            if (isCmd8 && respCtr != 3'd0) begin
              result.r7 <= {result.r7[23:0], rxByte};
            end else begin
              result.r1 <= rxByte;
            end
            state <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          if (isCmd8) begin
            // No timeout flag, an old card may just ignore CMD8
            if (timeoutCnt == TimeoutLimit) begin
              state <= ST_IDLE;
            end else if (respCtr == 3'd4) begin
              state <= ST_IDLE;
            end else if (respCtr == 3'd0 && result.r1 == 8'h05) begin
              // Illegal command, no R7 follows
              state <= ST_IDLE;
            end else if (respCtr == 3'd0 && result.r1[7]) begin
              state <= ST_POLL;
            end else begin
              respCtr    <= respCtr + 3'd1;
              timeoutCnt <= '0;
              state      <= ST_POLL;
            end
          end else begin
            if (timeoutCnt == TimeoutLimit) begin
              result.timeout <= (frame.cmd != CMD55);
              state          <= ST_IDLE;
            end else if (!result.r1[7]) begin
              state <= ST_IDLE;
            end else begin
              state <= ST_POLL;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/spiLink/spiByteShifter.sv ====
`timescale 1ns/100ps
`include "sdSpi_defs.svh"

module spiByteShifter (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] txByte,
  input  logic       txEmpty,
  output logic       txPop,
  output logic [7:0] rxByte,
  output logic       rxRdy,
  input  logic       rxRdyClr,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso
);

  localparam int DivW = $clog2(`SPI_CLK_DIV + 1);

  logic            busy;
  logic [DivW-1:0] divCnt;
  logic            halfTick;
  logic [2:0]      bitCnt;
  logic [7:0]      txShift;
  logic [7:0]      rxShift;

  assign halfTick = (divCnt == DivW'(`SPI_CLK_DIV - 1));
  // Pop straight from the FIFO head when idle
  assign txPop    = !busy && !txEmpty;

  ////////////////////
  // Mode 0 shifter
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      divCnt <= '0;
      bitCnt <= '0;
      sclk   <= 1'b0;
      mosi   <= 1'b1;
      rxRdy  <= 1'b0;
    end else begin
      if (rxRdyClr) begin
        rxRdy <= 1'b0;
      end
      if (!busy) begin
        if (!txEmpty) begin
          // First bit is on mosi before the first rising edge
          busy    <= 1'b1;
          txShift <= txByte;
          mosi    <= txByte[7];
          divCnt  <= '0;
          bitCnt  <= '0;
        end
      end else if (halfTick) begin
        divCnt <= '0;
        sclk   <= ~sclk;
        if (!sclk) begin
          // Rising edge, sample
          rxShift <= {rxShift[6:0], miso};
          if (bitCnt == 3'd7) begin
            // Completion wins over a clear in the same cycle
            rxByte <= {rxShift[6:0], miso};
            rxRdy  <= 1'b1;
          end
        end else begin
          // Falling edge, next bit out or done
          if (bitCnt == 3'd7) begin
            busy <= 1'b0;
          end else begin
            bitCnt  <= bitCnt + 3'd1;
            txShift <= {txShift[6:0], 1'b1};
            mosi    <= txShift[6];
          end
        end
      end else begin
        divCnt <= divCnt + 1'b1;
      end
    end
  end

endmodule

// ==== hw/spiLink/spiTxFifo.sv ====
`timescale 1ns/100ps
`include "sdSpi_defs.svh"

module spiTxFifo (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] wrByte,
  input  logic       wrEn,
  output logic       full,
  output logic [7:0] rdByte,
  input  logic       rdEn,
  output logic       empty
);

  localparam int Depth = `SPI_FIFO_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  logic [7:0]      mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            doWr;
  logic            doRd;

  assign full   = (count == CntW'(Depth));
  assign empty  = (count == '0);
  // Writes to a full FIFO and reads from an empty one are dropped
  assign doWr   = wrEn && !full;
  assign doRd   = rdEn && !empty;
  // Head byte shows without a read cycle
  assign rdByte = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doWr) begin
      mem[wrPtr] <= wrByte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // Pointers wrap at any depth
      if (doWr) begin
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doRd) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doWr, doRd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== common/axiLitePkg.sv ====
package axiLitePkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axiResp_e;

  // Master to slave, all five channels
  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axiLiteReq_t;

  // Slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    axiResp_e    bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    axiResp_e    rresp;
  } axiLiteRsp_t;

endpackage

// ==== common/sdCmdPkg.sv ====
package sdCmdPkg;

  // Command bytes the engine or the card treats specially
  typedef enum logic [7:0] {
    CMD0  = 8'h40,
    CMD8  = 8'h48,
    CMD17 = 8'h51,
    CMD55 = 8'h77
  } sdOpcode_e;

  // Sender FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_BYTE,
    ST_BYTE_GAP,
    ST_DRAIN,
    ST_POLL,
    ST_POLL_DEL,
    ST_WAIT,
    ST_CHECK
  } sdSendState_e;

  // Six bytes on the wire after the preamble
  typedef struct packed {
    logic [7:0]  cmd;
    logic [31:0] arg;
    logic [7:0]  crc;
  } sdCmdFrame_t;

  // Outcome of the last command
  typedef struct packed {
    logic        ready;
    logic        timeout;
    logic [7:0]  r1;
    logic [31:0] r7;
  } sdCmdResult_t;

endpackage

// ==== common/sdSpi_defs.svh ====
`ifndef SD_SPI_DEFS_SVH
`define SD_SPI_DEFS_SVH

////////////////////
// SD command timing
////////////////////

// Poll bytes sent before the card counts as silent
`define SD_RESP_TIMEOUT 64

// System clocks per half SPI clock period
`define SPI_CLK_DIV 2

// Entries in the byte FIFO towards the shifter
`define SPI_FIFO_DEPTH 4

////////////////////
// Register map, byte offsets
////////////////////

`define REG_CMD    8'h00
`define REG_ARG    8'h04
`define REG_CRC    8'h08
`define REG_STATUS 8'h0C
`define REG_R7     8'h10

`endif
